// ==== src/bmem_defs.svh ====
// ##########################################################
// Bit-masked memory block sizing
// Word width, word count and address width shared by the
// package, the RAM port interface and the top level
// ##########################################################

`ifndef BMEM_DEFS_SVH
`define BMEM_DEFS_SVH

// Data word width in bits
`define BMEM_WIDTH 32

// Number of words held by the RAM
`define BMEM_ELS 64

// Address width, enough to index every word
`define BMEM_ADDR_W 6

`endif

// ==== src/bmem_pkg.sv ====
// ##########################################################
// Bit-masked memory payload types
// Request and response words carried by the queues
// ##########################################################

`include "bmem_defs.svh"

package bmem_pkg;

    // Client request, 71 bits in total
    // A set mask bit means the matching data bit is written
    typedef struct packed {
        logic                    write;
        logic [`BMEM_ADDR_W-1:0] addr;
        logic [`BMEM_WIDTH-1:0]  data;
        logic [`BMEM_WIDTH-1:0]  mask;
    } req_t;

    // Read response, one word
    typedef struct packed {
        logic [`BMEM_WIDTH-1:0] data;
    } rsp_t;

endpackage

// ==== src/bmem_ram_if.sv ====
// ##########################################################
// Single RAM port between issue controller and RAM
// One read or one write per enabled edge
// ##########################################################

`timescale 1ns/1ps

`include "bmem_defs.svh"

interface bmem_ram_if;

    logic                    en;
    logic                    we;
    logic [`BMEM_ADDR_W-1:0] addr;
    logic [`BMEM_WIDTH-1:0]  wdata;
    // Per-bit write enable
    logic [`BMEM_WIDTH-1:0]  wmask;
    // Held read word
    logic [`BMEM_WIDTH-1:0]  rdata;

    modport ctrl (
        output en, we, addr, wdata, wmask,
        input  rdata
    );

    modport ram (
        input  en, we, addr, wdata, wmask,
        output rdata
    );

endinterface

// ==== src/bmem_fifo2.sv ====
// ##########################################################
// Two-entry valid/ready queue
// Registered decoupling for any payload type, no
// same-cycle pass-through
// ##########################################################

`timescale 1ns/1ps

module bmem_fifo2 #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_n_i,

    input  logic     in_valid_i,
    output logic     in_ready_o,
    input  payload_t in_data_i,

    output logic     out_valid_o,
    input  logic     out_ready_i,
    output payload_t out_data_o
);

    payload_t   slots [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    // Room left while fewer than two entries are held
    assign in_ready_o  = (count != 2'd2);
    assign out_valid_o = (count != 2'd0);
    assign out_data_o  = slots[rd_ptr];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop)
            begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;
            endcase
        end
    end

    // Payload storage
    always_ff @(posedge clk_i)
    begin
        if (push)
        begin
            slots[wr_ptr] <= in_data_i;
        end
    end

endmodule

// ==== src/bmem_1rw_mask.sv ====
// ##########################################################
// Synchronous single-port RAM with per-bit write mask
// One read or one write per enabled edge, read word held
// until the next access
// ##########################################################

`timescale 1ns/1ps

`include "bmem_defs.svh"

module bmem_1rw_mask #(
    parameter int width_p = `BMEM_WIDTH,
    parameter int els_p   = `BMEM_ELS
) (
    input  logic   clk_i,
    bmem_ram_if.ram ram
);

    logic [width_p-1:0] mem [els_p];
    logic [width_p-1:0] old_word;
    logic [width_p-1:0] new_word;

    // Masked merge of the addressed word
    assign old_word = mem[ram.addr];
    assign new_word = (old_word & ~ram.wmask) | (ram.wdata & ram.wmask);

    // Array update, contents are not initialised
    always_ff @(posedge clk_i)
    begin
        if (ram.en && ram.we)
        begin
            mem[ram.addr] <= new_word;
        end
    end

    // Output register, only a read reloads it
    always_ff @(posedge clk_i)
    begin
        if (ram.en && !ram.we)
        begin
            ram.rdata <= old_word;
        end
    end

endmodule

// ==== src/bmem_ctrl.sv ====
// ##########################################################
// Issue controller for the bit-masked memory
// Takes the queue head into the RAM and turns each held
// read word into a response for the response queue
// ##########################################################

`timescale 1ns/1ps

module bmem_ctrl (
    input  logic            clk_i,
    input  logic            rst_n_i,

    // Request queue head
    input  logic            req_valid_i,
    output logic            req_ready_o,
    input  bmem_pkg::req_t  req_i,

    // RAM port
    bmem_ram_if.ctrl        ram,

    // Response queue input
    output logic            rsp_valid_o,
    input  logic            rsp_ready_i,
    output bmem_pkg::rsp_t  rsp_o
);

    logic pending;
    logic out_free;
    logic issue;

    // RAM output may be overwritten once no read is waiting on it,
    // or the waiting read leaves on this edge
    assign out_free = !pending || rsp_ready_i;
    assign issue    = req_valid_i && out_free;

    assign req_ready_o = out_free;

    // Head request goes straight onto the port
    assign ram.en    = issue;
    assign ram.we    = req_i.write;
    assign ram.addr  = req_i.addr;
    assign ram.wdata = req_i.data;
    assign ram.wmask = req_i.mask;

    // Held read word offered as a response
    assign rsp_valid_o = pending;
    assign rsp_o       = '{data: ram.rdata};

    // Pending read flag
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            pending <= 1'b0;
        end
        else if (issue)
        begin
            // New read replaces any response pushed on this edge
            pending <= !req_i.write;
        end
        else if (rsp_ready_i)
        begin
            pending <= 1'b0;
        end
    end

endmodule

// ==== src/bmem_top.sv ====
// ##########################################################
// Bit-masked memory block, top level
// Request queue, issue controller, RAM and response queue
// behind plain valid/ready client ports
// ##########################################################

`timescale 1ns/1ps

`include "bmem_defs.svh"

module bmem_top (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    // Request channel
    input  logic                    req_valid_i,
    output logic                    req_ready_o,
    input  logic                    req_write_i,
    input  logic [`BMEM_ADDR_W-1:0] req_addr_i,
    input  logic [`BMEM_WIDTH-1:0]  req_data_i,
    input  logic [`BMEM_WIDTH-1:0]  req_mask_i,

    // Response channel
    output logic                    rsp_valid_o,
    input  logic                    rsp_ready_i,
    output logic [`BMEM_WIDTH-1:0]  rsp_data_o
);

    bmem_pkg::req_t req_in;
    bmem_pkg::req_t req_head;
    logic           req_head_valid;
    logic           req_head_ready;

    bmem_pkg::rsp_t rsp_push;
    logic           rsp_push_valid;
    logic           rsp_push_ready;
    bmem_pkg::rsp_t rsp_out;

    bmem_ram_if ram_port ();

    // Pack client fields into one request word
    assign req_in = '{
        write: req_write_i,
        addr:  req_addr_i,
        data:  req_data_i,
        mask:  req_mask_i
    };

    bmem_fifo2 #(.payload_t(bmem_pkg::req_t)) u_req_q (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (req_valid_i),
        .in_ready_o  (req_ready_o),
        .in_data_i   (req_in),
        .out_valid_o (req_head_valid),
        .out_ready_i (req_head_ready),
        .out_data_o  (req_head)
    );

    bmem_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_head_valid),
        .req_ready_o (req_head_ready),
        .req_i       (req_head),
        .ram         (ram_port.ctrl),
        .rsp_valid_o (rsp_push_valid),
        .rsp_ready_i (rsp_push_ready),
        .rsp_o       (rsp_push)
    );

    bmem_1rw_mask #(
        .width_p (`BMEM_WIDTH),
        .els_p   (`BMEM_ELS)
    ) u_ram (
        .clk_i (clk_i),
        .ram   (ram_port.ram)
    );

    bmem_fifo2 #(.payload_t(bmem_pkg::rsp_t)) u_rsp_q (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_valid_i  (rsp_push_valid),
        .in_ready_o  (rsp_push_ready),
        .in_data_i   (rsp_push),
        .out_valid_o (rsp_valid_o),
        .out_ready_i (rsp_ready_i),
        .out_data_o  (rsp_out)
    );

    assign rsp_data_o = rsp_out.data;

endmodule

// ==== test/bmem_assert.sv ====
// ##########################################################
// Protocol checks for the bit-masked memory block
// Response stall stability and RAM port rules, bound into
// the top level
// ##########################################################

`timescale 1ns/1ps

`include "bmem_defs.svh"

module bmem_assert (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic                    rsp_valid_i,
    input logic                    rsp_ready_i,
    input logic [`BMEM_WIDTH-1:0]  rsp_data_i,
    input logic                    ram_en_i,
    input logic [`BMEM_ADDR_W-1:0] ram_addr_i,
    input logic                    pending_i,
    input logic                    push_ready_i
);

    int error_count;

    initial
    begin
        error_count = 0;
    end

    // Stalled response stays put
    rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i))
    else
    begin
        $error("stalled response dropped or changed");
        error_count++;
    end

    ram_addr_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ram_en_i |-> int'(ram_addr_i) < `BMEM_ELS)
    else
    begin
        $error("RAM enabled with an address past the last word");
        error_count++;
    end

    // Held read word must survive until the response queue takes it
    ram_hold_rdata: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pending_i && !push_ready_i |-> !ram_en_i)
    else
    begin
        $error("RAM enabled while a read result was still waiting");
        error_count++;
    end

endmodule

bind bmem_top bmem_assert u_assert (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .rsp_valid_i  (rsp_valid_o),
    .rsp_ready_i  (rsp_ready_i),
    .rsp_data_i   (rsp_data_o),
    .ram_en_i     (ram_port.en),
    .ram_addr_i   (ram_port.addr),
    .pending_i    (rsp_push_valid),
    .push_ready_i (rsp_push_ready)
);

// ==== test/bmem_tb.sv ====
// ##########################################################
// Directed testbench for the bit-masked memory block
// Drives requests on the falling edge and checks every read
// response against a masked-write reference model
// ##########################################################

`timescale 1ns/1ps

`include "bmem_defs.svh"

module bmem_tb;

    localparam int          TIMEOUT   = 1000;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    logic                    clk_i;
    logic                    rst_n_i;
    logic                    req_valid_i;
    logic                    req_ready_o;
    logic                    req_write_i;
    logic [`BMEM_ADDR_W-1:0] req_addr_i;
    logic [`BMEM_WIDTH-1:0]  req_data_i;
    logic [`BMEM_WIDTH-1:0]  req_mask_i;
    logic                    rsp_valid_o;
    logic                    rsp_ready_i;
    logic [`BMEM_WIDTH-1:0]  rsp_data_o;

    // Reference contents and read results still owed
    logic [`BMEM_WIDTH-1:0]  model [`BMEM_ELS];
    logic [`BMEM_WIDTH-1:0]  exp_q [$];

    logic [31:0] lfsr_state;
    // Response ready pattern as 0 always high, 1 held low or 2 random
    int          ready_mode;
    string       test_name;

    bmem_top DUT (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_write_i (req_write_i),
        .req_addr_i  (req_addr_i),
        .req_data_i  (req_data_i),
        .req_mask_i  (req_mask_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_data_o  (rsp_data_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Galois LFSR stepped once per bit
    function automatic logic next_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out)
        begin
            lfsr_state = lfsr_state ^ LFSR_TAPS;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    // Each set mask bit takes the new data bit
    function automatic logic [`BMEM_WIDTH-1:0] merge_word(
        input logic [`BMEM_WIDTH-1:0] old_w,
        input logic [`BMEM_WIDTH-1:0] data,
        input logic [`BMEM_WIDTH-1:0] mask
    );
        logic [`BMEM_WIDTH-1:0] w;
        w = old_w;
        for (int i = 0; i < `BMEM_WIDTH; i++)
        begin
            if (mask[i])
            begin
                w[i] = data[i];
            end
        end
        return w;
    endfunction

    // Odd multiplier spreads every address bit over the word
    function automatic logic [`BMEM_WIDTH-1:0] word_for_addr(input logic [`BMEM_ADDR_W-1:0] a);
        return 32'h9e37_79b9 * {{(32-`BMEM_ADDR_W){1'b0}}, a} + 32'h0123_4567;
    endfunction

    task automatic report_fail(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    // Picks response ready for one cycle
    // A response that leaves on the next edge is checked here
    task automatic step_cycle();
        logic [`BMEM_WIDTH-1:0] expected;
        @(negedge clk_i);
        case (ready_mode)
            0:       rsp_ready_i = 1'b1;
            1:       rsp_ready_i = 1'b0;
            default: rsp_ready_i = next_bit();
        endcase
        if (rsp_valid_o && rsp_ready_i)
        begin
            assert (exp_q.size() > 0)
            else report_fail($sformatf("%s: a response came with no read outstanding",
                                       test_name));
            expected = exp_q.pop_front();
            assert (rsp_data_o === expected)
            else report_fail($sformatf("[FAIL] %s: expected %h, actual %h",
                                       test_name, expected, rsp_data_o));
        end
    endtask

    // Valid stays high until the next request or the drain
    task automatic send_req(
        input logic                    wr,
        input logic [`BMEM_ADDR_W-1:0] addr,
        input logic [`BMEM_WIDTH-1:0]  data,
        input logic [`BMEM_WIDTH-1:0]  mask
    );
        int waited;
        step_cycle();
        req_valid_i = 1'b1;
        req_write_i = wr;
        req_addr_i  = addr;
        req_data_i  = data;
        req_mask_i  = mask;
        waited = 0;
        while (!req_ready_o)
        begin
            step_cycle();
            waited++;
            assert (waited < TIMEOUT)
            else report_fail($sformatf("%s: request was never accepted", test_name));
        end
        if (wr)
        begin
            model[addr] = merge_word(model[addr], data, mask);
        end
        else
        begin
            exp_q.push_back(model[addr]);
        end
    endtask

    task automatic drain();
        int waited;
        step_cycle();
        req_valid_i = 1'b0;
        ready_mode  = 0;
        waited = 0;
        while (exp_q.size() > 0)
        begin
            step_cycle();
            waited++;
            assert (waited < TIMEOUT)
            else report_fail($sformatf("%s: %0d responses never arrived",
                                       test_name, exp_q.size()));
        end
        // A duplicated response would be caught here
        repeat (3) step_cycle();
    endtask

    task automatic test_reset();
        test_name = "reset_state";
        step_cycle();
        assert (req_ready_o === 1'b1)
        else report_fail($sformatf("[FAIL] %s: expected req_ready_o 1, actual %b",
                                   test_name, req_ready_o));
        assert (rsp_valid_o === 1'b0)
        else report_fail($sformatf("[FAIL] %s: expected rsp_valid_o 0, actual %b",
                                   test_name, rsp_valid_o));
    endtask

    task automatic test_full_rw();
        test_name = "full_write_readback";
        for (int a = 0; a < `BMEM_ELS; a++)
        begin
            send_req(1'b1, a[`BMEM_ADDR_W-1:0], word_for_addr(a[`BMEM_ADDR_W-1:0]), '1);
        end
        for (int a = 0; a < `BMEM_ELS; a++)
        begin
            send_req(1'b0, a[`BMEM_ADDR_W-1:0], '0, '0);
        end
        drain();
    endtask

    task automatic test_masked();
        logic [31:0]             r;
        logic [`BMEM_ADDR_W-1:0] addr;
        test_name = "masked_write";
        for (int i = 0; i < 8; i++)
        begin
            r = rand_bits(`BMEM_ADDR_W);
            addr = r[`BMEM_ADDR_W-1:0];
            send_req(1'b1, addr, word_for_addr(addr) ^ 32'hffff_0000, '1);
            send_req(1'b1, addr, rand_bits(32), rand_bits(32));
            send_req(1'b0, addr, '0, '0);
        end
        drain();
    endtask

    // Stalled responses fill the controller and both queues
    // Three reads absorbed and two more held in the request queue
    task automatic test_backpressure();
        int                      accepted;
        logic [`BMEM_ADDR_W-1:0] addr;
        test_name = "backpressure";
        ready_mode = 1;
        step_cycle();
        accepted = 0;
        while (req_ready_o && accepted < 16)
        begin
            addr = accepted[`BMEM_ADDR_W-1:0];
            req_valid_i = 1'b1;
            req_write_i = 1'b0;
            req_addr_i  = addr;
            req_data_i  = '0;
            req_mask_i  = '0;
            exp_q.push_back(model[addr]);
            accepted++;
            step_cycle();
        end
        req_valid_i = 1'b0;
        assert (accepted == 5)
        else report_fail($sformatf("[FAIL] %s: expected 5 reads accepted, actual %0d",
                                   test_name, accepted));
        drain();
    endtask

    task automatic test_random();
        logic [31:0]             r;
        logic                    wr;
        logic [`BMEM_ADDR_W-1:0] addr;
        logic [`BMEM_WIDTH-1:0]  data;
        logic [`BMEM_WIDTH-1:0]  mask;
        test_name = "random_mix";
        ready_mode = 2;
        for (int i = 0; i < 300; i++)
        begin
            wr = next_bit();
            r = rand_bits(`BMEM_ADDR_W);
            addr = r[`BMEM_ADDR_W-1:0];
            data = rand_bits(32);
            mask = rand_bits(32);
            send_req(wr, addr, data, mask);
        end
        drain();
    endtask

    initial
    begin
        lfsr_state  = 32'hc153_0bec;
        ready_mode  = 0;
        test_name   = "init";
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        req_addr_i  = '0;
        req_data_i  = '0;
        req_mask_i  = '0;
        rsp_ready_i = 1'b1;
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        test_reset();
        test_full_rw();
        test_masked();
        test_backpressure();
        test_random();

        if (DUT.u_assert.error_count == 0)
        begin
            $display("TEST OK");
            $finish;
        end
        else
        begin
            report_fail("a bound protocol assertion failed during the run");
        end
    end

endmodule

// ==== sources.f ====
+incdir+src
src/bmem_pkg.sv
src/bmem_ram_if.sv
src/bmem_fifo2.sv
src/bmem_1rw_mask.sv
src/bmem_ctrl.sv
src/bmem_top.sv
test/bmem_assert.sv
test/bmem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the bit-masked memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module bmem_tb \
    -f sources.f

sim_out=$(./obj_dir/Vbmem_tb 2>&1 || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1
